// File: hw/mci_params.svh
// Address map, sizes and bus widths of the management controller, included by RTL and testbench
`ifndef MCI_PARAMS_SVH
`define MCI_PARAMS_SVH

//////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////
`define MCI_ADDR_W 32
`define MCI_DATA_W 32
// AXI user tag carried with each request
`define MCI_USER_W 32

//////////////////////////////////////////////////
// Address map
//////////////////////////////////////////////////
// Register block, 4 KB window
`define MCI_REG_START 32'h0000_0000
`define MCI_REG_END 32'h0000_0FFF

// Local SRAM, size in KB
`define MCI_SRAM_SIZE_KB 1
`define MCI_SRAM_START 32'h0001_0000
`define MCI_SRAM_END (`MCI_SRAM_START + (`MCI_SRAM_SIZE_KB * 1024) - 1)

// Mailbox, 256 byte window
`define MCI_MBOX_START 32'h0002_0000
`define MCI_MBOX_END 32'h0002_00FF
// Mailbox data buffer in words
`define MCI_MBOX_DEPTH 16

//////////////////////////////////////////////////
// Constants
//////////////////////////////////////////////////
// Identity word, "MCI" plus revision
`define MCI_ID_VALUE 32'h4D43_4901

`endif

// File: hw/mci_pkg.sv
// Shared request types of the management controller, imported by every RTL module and the testbench
`include "mci_params.svh"

package mci_pkg;

    //////////////////////////////////////////////////
    // Request fields
    //////////////////////////////////////////////////
    // Byte address on the SoC port
    typedef logic [`MCI_ADDR_W-1:0] mci_addr_t;

    // Read and write data word
    typedef logic [`MCI_DATA_W-1:0] mci_data_t;

    // AXI user tag, compared against straps
    typedef logic [`MCI_USER_W-1:0] mci_user_t;

    //////////////////////////////////////////////////
    // Decode result
    //////////////////////////////////////////////////
    // One entry per window, NONE for a miss
    typedef enum logic [1:0] {
        TGT_REG  = 2'd0,
        TGT_SRAM = 2'd1,
        TGT_MBOX = 2'd2,
        TGT_NONE = 2'd3
    } mci_target_e;

endpackage

// File: hw/mci_axi_sub_decode.sv
// Decodes SoC requests to the register, SRAM and mailbox targets and merges their responses back
`timescale 1ns/1ps
`include "mci_params.svh"

module mci_axi_sub_decode (
    input  logic               clk,
    input  logic               reset,
    // SoC request port
    input  logic               soc_dv,
    input  mci_pkg::mci_addr_t soc_addr,
    input  logic               soc_write,
    input  mci_pkg::mci_data_t soc_wdata,
    input  mci_pkg::mci_user_t soc_user,
    output mci_pkg::mci_data_t soc_rdata,
    output logic               soc_hold,
    output logic               soc_error,
    // Strapped privileged users
    input  mci_pkg::mci_user_t strap_mcu_lsu_user,
    input  mci_pkg::mci_user_t strap_mcu_ifu_user,
    input  mci_pkg::mci_user_t strap_soc_config_user,
    input  mci_pkg::mci_user_t strap_sram_config_user,
    // Per target select
    output logic               reg_dv,
    output logic               sram_dv,
    output logic               mbox_dv,
    // Request copy shared by all targets
    output mci_pkg::mci_addr_t req_addr,
    output logic               req_write,
    output mci_pkg::mci_data_t req_wdata,
    output mci_pkg::mci_user_t req_user,
    // Target responses
    input  mci_pkg::mci_data_t reg_rdata,
    input  logic               reg_hold,
    input  logic               reg_error,
    input  mci_pkg::mci_data_t sram_rdata,
    input  logic               sram_hold,
    input  logic               sram_error,
    input  mci_pkg::mci_data_t mbox_rdata,
    input  logic               mbox_hold,
    input  logic               mbox_error,
    // Privilege flags
    output logic               mcu_req,
    output logic               soc_config_req,
    output logic               sram_config_req
);
    import mci_pkg::*;

    mci_target_e target;
    logic        soc_config_disable;
    logic        soc_config_force;
    logic        soc_config_match;

    //////////////////////////////////////////////////
    // Window decode
    //////////////////////////////////////////////////
    // Full address compare, windows never overlap
    always_comb begin
        if (soc_addr inside {[`MCI_REG_START:`MCI_REG_END]}) begin
            target = TGT_REG;
        end else if (soc_addr inside {[`MCI_SRAM_START:`MCI_SRAM_END]}) begin
            target = TGT_SRAM;
        end else if (soc_addr inside {[`MCI_MBOX_START:`MCI_MBOX_END]}) begin
            target = TGT_MBOX;
        end else begin
            target = TGT_NONE;
        end
    end

    // Qualify with dv before handing to a target
    assign reg_dv  = soc_dv & (target == TGT_REG);
    assign sram_dv = soc_dv & (target == TGT_SRAM);
    assign mbox_dv = soc_dv & (target == TGT_MBOX);

    // Same request fields go to every target
    assign req_addr  = soc_addr;
    assign req_write = soc_write;
    assign req_wdata = soc_wdata;
    assign req_user  = soc_user;

    //////////////////////////////////////////////////
    // Response merge
    //////////////////////////////////////////////////
    always_comb begin
        soc_rdata = '0;
        soc_hold  = 1'b0;
        soc_error = 1'b0;
        case (target)
            TGT_REG: begin
                soc_rdata = reg_rdata;
                soc_hold  = reg_hold;
                soc_error = reg_error;
            end
            TGT_SRAM: begin
                soc_rdata = sram_rdata;
                soc_hold  = sram_hold;
                soc_error = sram_error;
            end
            TGT_MBOX: begin
                soc_rdata = mbox_rdata;
                soc_hold  = mbox_hold;
                soc_error = mbox_error;
            end
            // Miss, zero data and error
            default: soc_error = soc_dv;
        endcase
    end

    //////////////////////////////////////////////////
    // Privileged user detect
    //////////////////////////////////////////////////
    // All zeros turns SoC-config off, all ones grants it to everyone
    assign soc_config_disable = ~|strap_soc_config_user;
    assign soc_config_force   = &strap_soc_config_user;
    assign soc_config_match   = (soc_user == strap_soc_config_user);

    assign soc_config_req = soc_dv & ((soc_config_match & ~soc_config_disable) | soc_config_force);

    // LSU and IFU collapse into one MCU flag
    assign mcu_req = soc_dv & ((soc_user == strap_mcu_lsu_user) |
                               (soc_user == strap_mcu_ifu_user));

    assign sram_config_req = soc_dv & (soc_user == strap_sram_config_user);

    // At most one target per request
    a_select_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0({reg_dv, sram_dv, mbox_dv}));

    // A target only stalls a request it owns
    a_hold_needs_dv: assert property (@(posedge clk) disable iff (reset)
        !((reg_hold & ~reg_dv) | (sram_hold & ~sram_dv) | (mbox_hold & ~mbox_dv)));

endmodule

// File: hw/mci_reg_block.sv
// Control registers of the management controller: identity, scratch and privileged SoC config
`timescale 1ns/1ps
`include "mci_params.svh"

module mci_reg_block (
    input  logic               clk,
    input  logic               reset,
    input  logic               dv,
    input  mci_pkg::mci_addr_t addr,
    input  logic               write,
    input  mci_pkg::mci_data_t wdata,
    input  logic               soc_config_req,
    output mci_pkg::mci_data_t rdata,
    output logic               hold,
    output logic               error,
    output mci_pkg::mci_data_t soc_config
);
    import mci_pkg::*;

    // Register offsets in the window
    localparam mci_addr_t ID_OFFS         = 'h0;
    localparam mci_addr_t SCRATCH_OFFS    = 'h4;
    localparam mci_addr_t SOC_CONFIG_OFFS = 'h8;

    mci_addr_t offset;
    mci_data_t scratch_q;
    mci_data_t soc_config_q;
    logic      wr_en;

    // Always single cycle
    assign hold   = 1'b0;
    assign offset = addr - mci_addr_t'(`MCI_REG_START);
    assign wr_en  = dv & write & ~hold;

    // Read mux, unmapped offsets read zero
    always_comb begin
        case (offset)
            ID_OFFS:         rdata = `MCI_ID_VALUE;
            SCRATCH_OFFS:    rdata = scratch_q;
            SOC_CONFIG_OFFS: rdata = soc_config_q;
            default:         rdata = '0;
        endcase
    end

    // Identity is read only, config needs the strap user
    assign error = wr_en & ((offset == ID_OFFS) |
                            ((offset == SOC_CONFIG_OFFS) & ~soc_config_req));

    always_ff @(posedge clk) begin
        if (reset) begin
            scratch_q    <= '0;
            soc_config_q <= '0;
        end else if (wr_en) begin
            // scratch is open to any user
            if (offset == SCRATCH_OFFS) begin
                scratch_q <= wdata;
            end
            if ((offset == SOC_CONFIG_OFFS) && soc_config_req) begin
                soc_config_q <= wdata;
            end
        end
    end

    assign soc_config = soc_config_q;

    // Write to the identity word leaves every register as it was
    a_id_wr_ignored: assert property (@(posedge clk) disable iff (reset)
        (wr_en && (offset == ID_OFFS)) |=> ($stable(scratch_q) && $stable(soc_config_q)));

endmodule

// File: hw/mci_sram_ctrl.sv
// Local word SRAM target: reads take two cycles with one hold cycle, writes need a privileged user
`timescale 1ns/1ps
`include "mci_params.svh"

module mci_sram_ctrl (
    input  logic               clk,
    input  logic               reset,
    input  logic               dv,
    input  mci_pkg::mci_addr_t addr,
    input  logic               write,
    input  mci_pkg::mci_data_t wdata,
    input  logic               mcu_req,
    input  logic               sram_config_req,
    output mci_pkg::mci_data_t rdata,
    output logic               hold,
    output logic               error
);
    import mci_pkg::*;

    // 256 words per KB
    localparam int DEPTH = `MCI_SRAM_SIZE_KB * 256;
    localparam int IDX_W = $clog2(DEPTH);

    mci_data_t        mem [DEPTH];
    mci_addr_t        offset;
    logic [IDX_W-1:0] idx;
    logic             rd_done;
    logic             wr_ok;

    // Word index within the window
    assign offset = addr - mci_addr_t'(`MCI_SRAM_START);
    assign idx    = offset[IDX_W+1:2];

    // MCU or SRAM-config user may write
    assign wr_ok = mcu_req | sram_config_req;
    assign error = dv & write & ~wr_ok;

    // Stall first read cycle while the word is fetched
    assign hold = dv & ~write & ~rd_done;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_done <= 1'b0;
        end else begin
            rd_done <= hold;
        end
    end

    // Array and read register
    always_ff @(posedge clk) begin
        if (hold) begin
            rdata <= mem[idx];
        end
        if (dv & write & wr_ok) begin
            mem[idx] <= wdata;
        end
    end

    // One stall cycle, then the same read completes with its data
    a_hold_single: assert property (@(posedge clk) disable iff (reset)
        hold |=> (!hold && dv && !write && $stable(addr)));

endmodule

// File: hw/mci_mbox.sv
// Mailbox target: lock acquired by reading, owner tracked by user tag, owner-only data writes
`timescale 1ns/1ps
`include "mci_params.svh"

module mci_mbox (
    input  logic               clk,
    input  logic               reset,
    input  logic               dv,
    input  mci_pkg::mci_addr_t addr,
    input  logic               write,
    input  mci_pkg::mci_data_t wdata,
    input  mci_pkg::mci_user_t user,
    output mci_pkg::mci_data_t rdata,
    output logic               hold,
    output logic               error
);
    import mci_pkg::*;

    // Register offsets
    localparam mci_addr_t LOCK_OFFS    = 'h00;
    localparam mci_addr_t OWNER_OFFS   = 'h04;
    localparam mci_addr_t RELEASE_OFFS = 'h08;
    localparam mci_addr_t DATA_OFFS    = 'h40;
    localparam int        IDX_W        = $clog2(`MCI_MBOX_DEPTH);

    mci_data_t        data_mem [`MCI_MBOX_DEPTH];
    mci_addr_t        offset;
    logic [IDX_W-1:0] idx;
    logic             lock_q;
    mci_user_t        owner_q;
    logic             is_owner;
    logic             in_data;
    logic             acquire;
    logic             rel_req;
    logic             data_wr;

    assign hold   = 1'b0;
    assign offset = addr - mci_addr_t'(`MCI_MBOX_START);
    assign idx    = offset[IDX_W+1:2];
    assign in_data = (offset >= DATA_OFFS) && (offset < DATA_OFFS + 4 * `MCI_MBOX_DEPTH);

    // Owner only counts while locked
    assign is_owner = lock_q & (user == owner_q);

    // Lock read grabs an idle mailbox
    assign acquire = dv & ~write & (offset == LOCK_OFFS) & ~lock_q;
    assign rel_req = dv & write & (offset == RELEASE_OFFS);
    assign data_wr = dv & write & in_data;

    // Release and data writes belong to the owner
    assign error = (rel_req | data_wr) & ~is_owner;

    // Read mux, data open to any user
    always_comb begin
        if (in_data) begin
            rdata = data_mem[idx];
        end else begin
            case (offset)
                LOCK_OFFS:  rdata = mci_data_t'(lock_q);
                OWNER_OFFS: rdata = mci_data_t'(owner_q);
                default:    rdata = '0;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Lock and owner
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            lock_q  <= 1'b0;
            owner_q <= '0;
        end else if (acquire) begin
            lock_q  <= 1'b1;
            owner_q <= user;
        end else if (rel_req & is_owner) begin
            lock_q <= 1'b0;
        end
    end

    // Data buffer
    always_ff @(posedge clk) begin
        if (data_wr & is_owner) begin
            data_mem[idx] <= wdata;
        end
    end

    // No owner swap while somebody holds the lock
    a_owner_stable: assert property (@(posedge clk) disable iff (reset)
        !$stable(owner_q) |-> $past(!lock_q || (rel_req && is_owner)));

endmodule

// File: hw/mci_top.sv
// Top of the management controller subsystem: SoC request port, decoder and the three targets
`timescale 1ns/1ps
`include "mci_params.svh"

module mci_top (
    input  logic               clk,
    input  logic               reset,
    // SoC request port
    input  logic               soc_dv,
    input  mci_pkg::mci_addr_t soc_addr,
    input  logic               soc_write,
    input  mci_pkg::mci_data_t soc_wdata,
    input  mci_pkg::mci_user_t soc_user,
    output mci_pkg::mci_data_t soc_rdata,
    output logic               soc_hold,
    output logic               soc_error,
    // Straps
    input  mci_pkg::mci_user_t strap_mcu_lsu_user,
    input  mci_pkg::mci_user_t strap_mcu_ifu_user,
    input  mci_pkg::mci_user_t strap_soc_config_user,
    input  mci_pkg::mci_user_t strap_sram_config_user,
    // Config register and privilege flags
    output mci_pkg::mci_data_t soc_config,
    output logic               mcu_req,
    output logic               soc_config_req,
    output logic               sram_config_req
);
    import mci_pkg::*;

    // Target selects
    logic      reg_dv;
    logic      sram_dv;
    logic      mbox_dv;
    // Shared request copy
    mci_addr_t req_addr;
    logic      req_write;
    mci_data_t req_wdata;
    mci_user_t req_user;
    // Target responses
    mci_data_t reg_rdata;
    logic      reg_hold;
    logic      reg_error;
    mci_data_t sram_rdata;
    logic      sram_hold;
    logic      sram_error;
    mci_data_t mbox_rdata;
    logic      mbox_hold;
    logic      mbox_error;

    mci_axi_sub_decode i_decode (
        .clk, .reset,
        .soc_dv, .soc_addr, .soc_write, .soc_wdata, .soc_user,
        .soc_rdata, .soc_hold, .soc_error,
        .strap_mcu_lsu_user, .strap_mcu_ifu_user,
        .strap_soc_config_user, .strap_sram_config_user,
        .reg_dv, .sram_dv, .mbox_dv,
        .req_addr, .req_write, .req_wdata, .req_user,
        .reg_rdata, .reg_hold, .reg_error,
        .sram_rdata, .sram_hold, .sram_error,
        .mbox_rdata, .mbox_hold, .mbox_error,
        .mcu_req, .soc_config_req, .sram_config_req
    );

    // Register block
    mci_reg_block i_reg_block (
        .clk, .reset,
        .dv(reg_dv), .addr(req_addr), .write(req_write), .wdata(req_wdata),
        .soc_config_req,
        .rdata(reg_rdata), .hold(reg_hold), .error(reg_error),
        .soc_config
    );

    // SRAM
    mci_sram_ctrl i_sram_ctrl (
        .clk, .reset,
        .dv(sram_dv), .addr(req_addr), .write(req_write), .wdata(req_wdata),
        .mcu_req, .sram_config_req,
        .rdata(sram_rdata), .hold(sram_hold), .error(sram_error)
    );

    // Mailbox, the only target that looks at the user tag directly
    mci_mbox i_mbox (
        .clk, .reset,
        .dv(mbox_dv), .addr(req_addr), .write(req_write), .wdata(req_wdata),
        .user(req_user),
        .rdata(mbox_rdata), .hold(mbox_hold), .error(mbox_error)
    );

endmodule

// File: test/tb_mci_top.sv
// Table-driven testbench for the management controller top level, run by the simulator through files.f
`timescale 1ns/1ps
`include "mci_params.svh"

module tb_mci_top;
    import mci_pkg::*;

    localparam int CLK_PERIOD = 40;

    // Users seen on the SoC port
    localparam mci_user_t USER_LSU  = 32'h0000_1001;
    localparam mci_user_t USER_IFU  = 32'h0000_1002;
    localparam mci_user_t USER_CFG  = 32'h0000_2000;
    localparam mci_user_t USER_SRAM = 32'h0000_3000;
    localparam mci_user_t USER_A    = 32'h0000_00A1;
    localparam mci_user_t USER_B    = 32'h0000_00B2;

    logic      clk;
    logic      reset;
    logic      soc_dv;
    mci_addr_t soc_addr;
    logic      soc_write;
    mci_data_t soc_wdata;
    mci_user_t soc_user;
    mci_data_t soc_rdata;
    logic      soc_hold;
    logic      soc_error;
    mci_user_t strap_mcu_lsu_user;
    mci_user_t strap_mcu_ifu_user;
    mci_user_t strap_soc_config_user;
    mci_user_t strap_sram_config_user;
    mci_data_t soc_config;
    logic      mcu_req;
    logic      soc_config_req;
    logic      sram_config_req;

    // Stimulus table, one queue per column
    string     names[$];
    mci_addr_t addrs[$];
    logic      writes[$];
    mci_data_t datas[$];
    mci_user_t users[$];
    mci_data_t exp_rdatas[$];
    logic      exp_errors[$];
    logic      cfg_alls[$];
    mci_data_t exp_cfgs[$];

    logic [31:0] lfsr_state;
    mci_data_t   cfg_model;
    logic        table_built;
    int          errors;
    int          checks;

    mci_top i_mci_top (
        .clk, .reset,
        .soc_dv, .soc_addr, .soc_write, .soc_wdata, .soc_user,
        .soc_rdata, .soc_hold, .soc_error,
        .strap_mcu_lsu_user, .strap_mcu_ifu_user,
        .strap_soc_config_user, .strap_sram_config_user,
        .soc_config, .mcu_req, .soc_config_req, .sram_config_req
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////
    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // One LFSR step per bit of the word
    task automatic random_word(output mci_data_t w);
        w = '0;
        for (int b = 0; b < 32; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
    endtask

    task automatic add_row(input string name, input mci_addr_t addr, input logic write,
                           input mci_data_t data, input mci_user_t user,
                           input mci_data_t exp_rdata, input logic exp_error,
                           input logic cfg_all);
        names.push_back(name);
        addrs.push_back(addr);
        writes.push_back(write);
        datas.push_back(data);
        users.push_back(user);
        exp_rdatas.push_back(exp_rdata);
        exp_errors.push_back(exp_error);
        cfg_alls.push_back(cfg_all);
        // soc_config as it should look during this row
        exp_cfgs.push_back(cfg_model);
    endtask

    // Strap rule: MCU is LSU or IFU, SoC config off at zero and open to all at ones
    function automatic logic [2:0] expected_flags(input mci_user_t user);
        logic mcu;
        logic cfg;
        logic sram;
        mcu = (user == strap_mcu_lsu_user) || (user == strap_mcu_ifu_user);
        if (strap_soc_config_user == '1) begin
            cfg = 1'b1;
        end else if (strap_soc_config_user == '0) begin
            cfg = 1'b0;
        end else begin
            cfg = (user == strap_soc_config_user);
        end
        sram = (user == strap_sram_config_user);
        return {mcu, cfg, sram};
    endfunction

    // SRAM reads stall one cycle, every other request completes at once
    function automatic int expected_stalls(input mci_addr_t addr, input logic write);
        if (!write && (addr >= `MCI_SRAM_START) && (addr <= `MCI_SRAM_END)) begin
            return 1;
        end
        return 0;
    endfunction

    task automatic mismatch(input string name, input string what,
                            input logic [31:0] expected, input logic [31:0] actual);
        $display("[ERROR] %s %s: expected %h, actual %h", name, what, expected, actual);
        errors++;
    endtask

    //////////////////////////////////////////////////
    // Table
    //////////////////////////////////////////////////
    task automatic build_table();
        mci_data_t w;
        mci_data_t sram_words[4];
        mci_addr_t sram_addrs[4];
        sram_addrs = '{32'h0001_0000, 32'h0001_0004, 32'h0001_0100, 32'h0001_03FC};
        cfg_model = '0;
        // Decode and miss
        add_row("id_read", 32'h0000_0000, 0, 0, USER_A, `MCI_ID_VALUE, 0, 0);
        add_row("miss_gap", 32'h0000_8000, 0, 0, USER_A, 0, 1, 0);
        add_row("miss_high", 32'h0003_0000, 0, 0, USER_A, 0, 1, 0);
        add_row("miss_sram_end", 32'h0001_0400, 0, 0, USER_LSU, 0, 1, 0);
        // Register privilege
        random_word(w);
        add_row("scratch_wr", 32'h0000_0004, 1, w, USER_A, 0, 0, 0);
        add_row("scratch_rd", 32'h0000_0004, 0, 0, USER_B, w, 0, 0);
        add_row("cfg_wr_unpriv", 32'h0000_0008, 1, 32'h1234_5678, USER_A, 0, 1, 0);
        add_row("cfg_rd_unchanged", 32'h0000_0008, 0, 0, USER_A, 0, 0, 0);
        random_word(w);
        add_row("cfg_wr_priv", 32'h0000_0008, 1, w, USER_CFG, 0, 0, 0);
        cfg_model = w;
        add_row("cfg_rd", 32'h0000_0008, 0, 0, USER_A, w, 0, 0);
        add_row("id_wr", 32'h0000_0000, 1, 32'hDEAD_BEEF, USER_CFG, 0, 1, 0);
        add_row("id_rd_after", 32'h0000_0000, 0, 0, USER_A, `MCI_ID_VALUE, 0, 0);
        // SRAM writes by the MCU, then back-to-back reads
        for (int k = 0; k < 4; k++) begin
            random_word(sram_words[k]);
            add_row("sram_wr", sram_addrs[k], 1, sram_words[k], USER_LSU, 0, 0, 0);
        end
        for (int k = 0; k < 4; k++) begin
            add_row("sram_rd", sram_addrs[k], 0, 0, USER_A, sram_words[k], 0, 0);
        end
        add_row("sram_wr_unpriv", sram_addrs[1], 1, ~sram_words[1], USER_B, 0, 1, 0);
        add_row("sram_rd_old", sram_addrs[1], 0, 0, USER_B, sram_words[1], 0, 0);
        random_word(w);
        add_row("sram_wr_ifu", 32'h0001_0008, 1, w, USER_IFU, 0, 0, 0);
        add_row("sram_rd_ifu", 32'h0001_0008, 0, 0, USER_A, w, 0, 0);
        random_word(w);
        add_row("sram_wr_cfg", 32'h0001_000C, 1, w, USER_SRAM, 0, 0, 0);
        add_row("sram_rd_cfg", 32'h0001_000C, 0, 0, USER_A, w, 0, 0);
        // Mailbox lock sequence
        add_row("mbox_lock_a", 32'h0002_0000, 0, 0, USER_A, 0, 0, 0);
        add_row("mbox_lock_a2", 32'h0002_0000, 0, 0, USER_A, 1, 0, 0);
        add_row("mbox_owner_a", 32'h0002_0004, 0, 0, USER_B, USER_A, 0, 0);
        add_row("mbox_data_wr_b", 32'h0002_0040, 1, 32'h0BAD_0BAD, USER_B, 0, 1, 0);
        random_word(w);
        add_row("mbox_data_wr_a", 32'h0002_0040, 1, w, USER_A, 0, 0, 0);
        add_row("mbox_data_rd_b", 32'h0002_0040, 0, 0, USER_B, w, 0, 0);
        add_row("mbox_release_b", 32'h0002_0008, 1, 0, USER_B, 0, 1, 0);
        add_row("mbox_lock_b_busy", 32'h0002_0000, 0, 0, USER_B, 1, 0, 0);
        add_row("mbox_release_a", 32'h0002_0008, 1, 0, USER_A, 0, 0, 0);
        add_row("mbox_lock_b", 32'h0002_0000, 0, 0, USER_B, 0, 0, 0);
        add_row("mbox_owner_b", 32'h0002_0004, 0, 0, USER_A, USER_B, 0, 0);
        // Each strapped user once, flags are checked on every row
        add_row("flag_lsu", 32'h0000_0000, 0, 0, USER_LSU, `MCI_ID_VALUE, 0, 0);
        add_row("flag_ifu", 32'h0000_0000, 0, 0, USER_IFU, `MCI_ID_VALUE, 0, 0);
        add_row("flag_cfg", 32'h0000_0000, 0, 0, USER_CFG, `MCI_ID_VALUE, 0, 0);
        add_row("flag_sram", 32'h0000_0000, 0, 0, USER_SRAM, `MCI_ID_VALUE, 0, 0);
        // All-ones SoC-config strap opens config to everyone
        add_row("all_flag_a", 32'h0000_0000, 0, 0, USER_A, `MCI_ID_VALUE, 0, 1);
        add_row("all_flag_lsu", 32'h0000_0000, 0, 0, USER_LSU, `MCI_ID_VALUE, 0, 1);
        random_word(w);
        add_row("all_cfg_wr_b", 32'h0000_0008, 1, w, USER_B, 0, 0, 1);
        cfg_model = w;
        add_row("all_cfg_rd", 32'h0000_0008, 0, 0, USER_A, w, 0, 1);
    endtask

    //////////////////////////////////////////////////
    // Watchdog
    //////////////////////////////////////////////////
    initial begin
        wait (table_built);
        #((names.size() * 3 + 20) * CLK_PERIOD);
        $display("Timeout: the request sequence did not finish in the expected time");
        $display("Verification failed");
        $finish;
    end

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        logic [2:0] flags;
        int         stalls;
        reset                  <= 1'b1;
        soc_dv                 <= 1'b0;
        soc_addr               <= '0;
        soc_write              <= 1'b0;
        soc_wdata              <= '0;
        soc_user               <= '0;
        strap_mcu_lsu_user     <= USER_LSU;
        strap_mcu_ifu_user     <= USER_IFU;
        strap_soc_config_user  <= USER_CFG;
        strap_sram_config_user <= USER_SRAM;
        errors      = 0;
        checks      = 0;
        lfsr_state  = 32'hb86e_0068;
        table_built = 1'b0;
        build_table();
        table_built = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < names.size(); i++) begin
            soc_dv                <= 1'b1;
            soc_addr              <= addrs[i];
            soc_write             <= writes[i];
            soc_wdata             <= datas[i];
            soc_user              <= users[i];
            strap_soc_config_user <= cfg_alls[i] ? '1 : USER_CFG;
            // Sample mid cycle once the stall is gone
            stalls = 0;
            @(negedge clk);
            while (soc_hold !== 1'b0) begin
                stalls++;
                @(negedge clk);
            end
            checks++;
            if (stalls != expected_stalls(addrs[i], writes[i])) begin
                mismatch(names[i], "hold cycles", expected_stalls(addrs[i], writes[i]), stalls);
            end
            if (!writes[i] && soc_rdata !== exp_rdatas[i]) begin
                mismatch(names[i], "rdata", exp_rdatas[i], soc_rdata);
            end
            if (soc_error !== exp_errors[i]) begin
                mismatch(names[i], "error", 32'(exp_errors[i]), 32'(soc_error));
            end
            flags = expected_flags(users[i]);
            if ({mcu_req, soc_config_req, sram_config_req} !== flags) begin
                mismatch(names[i], "flags", 32'(flags),
                         32'({mcu_req, soc_config_req, sram_config_req}));
            end
            if (soc_config !== exp_cfgs[i]) begin
                mismatch(names[i], "soc_config", exp_cfgs[i], soc_config);
            end
            // Request completes on this edge
            @(posedge clk);
        end
        soc_dv <= 1'b0;
        @(negedge clk);
        if (soc_config !== cfg_model) begin
            mismatch("final", "soc_config", cfg_model, soc_config);
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+hw
hw/mci_pkg.sv
hw/mci_axi_sub_decode.sv
hw/mci_reg_block.sv
hw/mci_sram_ctrl.sv
hw/mci_mbox.sv
hw/mci_top.sv
test/tb_mci_top.sv

// File: Bender.yml
package:
  name: mci

export_include_dirs:
  - hw

sources:
  - files:
      - hw/mci_pkg.sv
      - hw/mci_axi_sub_decode.sv
      - hw/mci_reg_block.sv
      - hw/mci_sram_ctrl.sv
      - hw/mci_mbox.sv
      - hw/mci_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/tb_mci_top.sv
